/* verilog.f */
hw/router_link_pkg.sv
hw/router_tx_bs.sv
hw/router_rx_bs.sv
hw/router_link_regs.sv
hw/router_link.sv
testbench/router_link_asserts.sv
testbench/router_link_checker.sv
testbench/tb_router_link.sv

/* Makefile */
# Verilator build and run for the router link port

VERILATOR ?= verilator
TOP       ?= tb_router_link
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* testbench/tb_router_link.sv */
`timescale 1ns/100ps

module tb_router_link;
	import router_link_pkg::*;

	localparam int WAIT_MAX = 400;  // clocks per wait loop
	localparam int N_ROWS   = 5;

	typedef struct packed {
		logic [7:0]        id;
		logic [DATA_W-1:0] word;
		logic [DATA_W-1:0] word_b;    // second word, pair rows only
		logic [7:0]        cts_low;   // clocks of cts low after the write
		logic [3:0]        wr_hold;   // clocks the write cycle stays up
		logic              pair;
		logic              bad_stop;  // forced frame instead of loopback
		logic              exp_err;
	} stim_t;

	logic              sclk;
	logic              rst_i;
	wb_req_t           wb_req;
	logic              cs;
	logic              ack;
	logic [DATA_W-1:0] dat;
	logic [NIB_W-1:0]  txd;
	logic              cts;
	logic [NIB_W-1:0]  rxd;
	logic              force_en;   // rxd from force_nib, else loopback
	logic [NIB_W-1:0]  force_nib;
	logic              chk_dat;
	logic              is_sts;
	logic [DATA_W-1:0] exp_dat;
	logic [DATA_W-1:0] msk_dat;
	logic              chk_idle;
	logic              fault;
	logic              test_end;
	logic [7:0]        test_id;
	logic              report;
	logic              all_ok;
	stim_t             tbl [N_ROWS];
	int                seed = 27;

	assign rxd = force_en ? force_nib : txd;  // link mux

	router_link dut (
		.rst_i    (rst_i),
		.sclk     (sclk),
		.wb_req_i (wb_req),
		.cs_i     (cs),
		.ack_o    (ack),
		.dat_o    (dat),
		.txd_o    (txd),
		.cts_i    (cts),
		.rxd_i    (rxd)
	);

	router_link_checker chk (
		.sclk       (sclk),
		.ack_i      (ack),
		.dat_i      (dat),
		.txd_i      (txd),
		.chk_dat_i  (chk_dat),
		.is_sts_i   (is_sts),
		.exp_dat_i  (exp_dat),
		.msk_dat_i  (msk_dat),
		.chk_idle_i (chk_idle),
		.fault_i    (fault),
		.test_end_i (test_end),
		.test_id_i  (test_id),
		.report_i   (report),
		.ok_o       (all_ok)
	);

	initial begin
		sclk = 1'b0;
		forever #5 sclk = ~sclk;
	end

	// ====================
	// bus and link tasks
	// ====================
	// all tasks start and end on a falling edge
	task automatic bus_idle();
		wb_req = '0;
		cs     = 1'b0;
	endtask

	task automatic bus_drive(input adr_e adr, input logic we, input logic [DATA_W-1:0] d);
		wb_req.cyc = 1'b1;
		wb_req.stb = 1'b1;
		wb_req.we  = we;
		wb_req.adr = adr;
		wb_req.dat = d;
		cs         = 1'b1;
	endtask

	task automatic write_tx(input logic [DATA_W-1:0] w, input logic [3:0] hold);
		bus_drive(ADR_TXDATA, 1'b1, w);
		repeat (hold) @(negedge sclk);  // held cycle still one write
		bus_idle();
	endtask

	task automatic read_check(input adr_e adr, input logic [DATA_W-1:0] exp,
		input logic [DATA_W-1:0] msk);
		bus_drive(adr, 1'b0, '0);
		chk_dat = 1'b1;
		is_sts  = (adr == ADR_STATUS);
		exp_dat = exp;
		msk_dat = msk;
		@(negedge sclk);
		chk_dat = 1'b0;
		bus_idle();
	endtask

	task automatic raise_fault(input string msg);
		$display("%s", msg);
		fault = 1'b1;
		@(negedge sclk);
		fault = 1'b0;
	endtask

	// poll status until a masked flag is set
	task automatic wait_flag(input logic [3:0] msk, input string what);
		int n;
		n = 0;
		bus_drive(ADR_STATUS, 1'b0, '0);
		@(negedge sclk);
		while ((dat[3:0] & msk) == 4'b0000 && n < WAIT_MAX) begin
			@(negedge sclk);
			n++;
		end
		bus_idle();
		if (n >= WAIT_MAX)
			raise_fault($sformatf("timeout: %s not set within %0d clocks", what, WAIT_MAX));
	endtask

	// line idle and status fixed for a number of clocks
	task automatic watch_line(input int cycles, input logic [3:0] sts, input logic [3:0] msk);
		bus_drive(ADR_STATUS, 1'b0, '0);
		chk_dat  = 1'b1;
		chk_idle = 1'b1;
		is_sts   = 1'b1;
		exp_dat  = DATA_W'(sts);
		msk_dat  = DATA_W'(msk);
		repeat (cycles) @(negedge sclk);
		chk_dat  = 1'b0;
		chk_idle = 1'b0;
		bus_idle();
	endtask

	task automatic send_nib(input logic [NIB_W-1:0] n);
		force_nib = n;
		repeat (NIB_CYC) @(negedge sclk);
	endtask

	task automatic send_forced(input logic [DATA_W-1:0] w, input logic [NIB_W-1:0] stop);
		int k;
		force_en = 1'b1;
		send_nib(START_NIB);
		for (k = 0; k < DATA_W / NIB_W; k++)
			send_nib(w[k*NIB_W +: NIB_W]);  // lsn first
		send_nib(stop);
		force_nib = IDLE_NIB;
		force_en  = 1'b0;
	endtask

	// rx_ready, word, then flags cleared by the read
	task automatic receive_word(input logic [DATA_W-1:0] w, input logic err);
		wait_flag(4'b0010, "rx_ready");
		read_check(ADR_STATUS, DATA_W'({2'b00, 1'b1, err}), DATA_W'(4'b0011));
		read_check(ADR_RXDATA, w, '1);
		read_check(ADR_STATUS, '0, DATA_W'(4'b0011));
	endtask

	task automatic finish_test(input logic [7:0] id);
		test_id  = id;
		test_end = 1'b1;
		@(negedge sclk);
		test_end = 1'b0;
	endtask

	task automatic set_row(input int i, input int id, input int cts_low, input int hold,
		input logic pair, input logic bad, input logic err);
		tbl[i].id       = 8'(id);
		tbl[i].cts_low  = 8'(cts_low);
		tbl[i].wr_hold  = 4'(hold);
		tbl[i].pair     = pair;
		tbl[i].bad_stop = bad;
		tbl[i].exp_err  = err;
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int    i;
		stim_t e;
		rst_i     = 1'b1;
		bus_idle();
		cts       = 1'b1;
		force_en  = 1'b0;
		force_nib = IDLE_NIB;
		chk_dat   = 1'b0;
		chk_idle  = 1'b0;
		is_sts    = 1'b0;
		exp_dat   = '0;
		msk_dat   = '0;
		fault     = 1'b0;
		test_end  = 1'b0;
		test_id   = '0;
		report    = 1'b0;

		//       id cts hold pair bad  err
		set_row(0, 2,  0,  1, 1'b0, 1'b0, 1'b0);  // loopback
		set_row(1, 3, 40,  1, 1'b0, 1'b0, 1'b0);  // cts held low
		set_row(2, 4,  0,  1, 1'b1, 1'b0, 1'b0);  // back to back
		set_row(3, 5,  0,  1, 1'b0, 1'b1, 1'b1);  // bad stop nibble
		set_row(4, 6,  0,  6, 1'b0, 1'b0, 1'b0);  // held bus cycle
		for (i = 0; i < N_ROWS; i++) begin
			tbl[i].word   = {$random(seed), $random(seed), $random(seed), $random(seed)};
			tbl[i].word_b = {$random(seed), $random(seed), $random(seed), $random(seed)};
		end

		repeat (2) @(negedge sclk);
		rst_i = 1'b0;

		watch_line(1, 4'b1000, 4'b1111);  // tx_empty only
		finish_test(8'd1);

		for (i = 0; i < N_ROWS; i++) begin
			e = tbl[i];
			if (e.bad_stop) begin
				send_forced(e.word, 4'h5);
				receive_word(e.word, e.exp_err);
			end else begin
				cts = (e.cts_low == 8'd0);
				write_tx(e.word, e.wr_hold);
				if (e.cts_low != 8'd0) begin
					watch_line(int'(e.cts_low), 4'b0000, 4'b1111);  // word parked
					cts = 1'b1;
				end
				if (e.pair) begin
					wait_flag(4'b1000, "tx_empty");
					write_tx(e.word_b, 4'd1);
				end
				receive_word(e.word, e.exp_err);
				if (e.pair)
					receive_word(e.word_b, 1'b0);
				if (e.wr_hold > 4'd1)
					watch_line(FRAME_CYC + NIB_CYC, 4'b1000, 4'b1111);  // no second frame
			end
			finish_test(e.id);
		end

		report = 1'b1;
		@(negedge sclk);
		report = 1'b0;
		@(negedge sclk);
		if (all_ok)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* testbench/router_link_checker.sv */
`timescale 1ns/100ps

module router_link_checker (
	input  logic                               sclk,
	input  logic                               ack_i,       // dut.ack_o
	input  logic [router_link_pkg::DATA_W-1:0] dat_i,       // dut.dat_o
	input  logic [router_link_pkg::NIB_W-1:0]  txd_i,       // dut.txd_o
	input  logic                               chk_dat_i,   // compare read data this clock
	input  logic                               is_sts_i,    // read data is the status word
	input  logic [router_link_pkg::DATA_W-1:0] exp_dat_i,
	input  logic [router_link_pkg::DATA_W-1:0] msk_dat_i,
	input  logic                               chk_idle_i,  // txd must be idle this clock
	input  logic                               fault_i,     // timeout seen by the top
	input  logic                               test_end_i,
	input  logic [7:0]                         test_id_i,
	input  logic                               report_i,
	output logic                               ok_o
);
	import router_link_pkg::*;

	int n_checks    = 0;
	int n_errs      = 0;  // all tests
	int test_errs   = 0;  // current test only
	int n_tests     = 0;
	int n_bad_tests = 0;

	assign ok_o = (n_errs == 0) && (n_tests > 0);

	// sampled like a flop, so values are the ones from before the edge
	always @(posedge sclk) begin
		if (chk_dat_i) begin
			n_checks++;
			if (!ack_i) begin
				$display("ERROR t=%0t bus read got no acknowledge", $time);
				n_errs++;
				test_errs++;
			end else if ((dat_i & msk_dat_i) !== (exp_dat_i & msk_dat_i)) begin
				n_errs++;
				test_errs++;
				if (is_sts_i)
					$display("MISMATCH t=%0t status expected %b (mask %b) got %b",
						$time, exp_dat_i[3:0], msk_dat_i[3:0], dat_i[3:0]);
				else
					$display("MISMATCH t=%0t dat_o expected %h got %h",
						$time, exp_dat_i, dat_i);
			end
		end
		if (chk_idle_i) begin
			n_checks++;
			if (txd_i !== IDLE_NIB) begin
				$display("MISMATCH t=%0t txd_o expected %h got %h", $time, IDLE_NIB, txd_i);
				n_errs++;
				test_errs++;
			end
		end
		if (fault_i) begin
			n_errs++;
			test_errs++;
		end
		// ====================
		// reporting
		// ====================
		if (test_end_i) begin
			n_tests++;
			if (test_errs == 0)
				$display("test %0d ok", test_id_i);
			else begin
				$display("test %0d: %0d errors", test_id_i, test_errs);
				n_bad_tests++;
			end
			test_errs = 0;
		end
		if (report_i)
			$display("checks %0d, tests %0d, failing tests %0d, errors %0d",
				n_checks, n_tests, n_bad_tests, n_errs);
	end

endmodule

/* testbench/router_link_asserts.sv */
`timescale 1ns/100ps

module router_link_asserts (
	input logic                              sclk,
	input logic                              rst_i,
	input logic                              wr_i,
	input logic                              empty_o,
	input logic                              busy_o,
	input logic [router_link_pkg::NIB_W-1:0] txd_o
);
	import router_link_pkg::*;

	// line idles high outside a frame
	a_idle_line: assert property (@(posedge sclk) disable iff (rst_i)
		!busy_o |-> txd_o == IDLE_NIB)
		else $error("txd_o left idle while no frame is running");

	// holding register fills one clock after the write edge
	a_load: assert property (@(posedge sclk) disable iff (rst_i)
		$rose(wr_i) && empty_o |=> $fell(empty_o))
		else $error("empty_o did not fall one clock after the write edge");

endmodule

bind router_tx_bs router_link_asserts u_asserts (
	.sclk    (sclk),
	.rst_i   (rst_i),
	.wr_i    (wr_i),
	.empty_o (empty_o),
	.busy_o  (busy_o),
	.txd_o   (txd_o)
);

/* hw/router_link.sv */
`timescale 1ns/100ps

module router_link (
	input  logic                                rst_i,
	input  logic                                sclk,
	// bus slave
	input  router_link_pkg::wb_req_t            wb_req_i,
	input  logic                                cs_i,
	output logic                                ack_o,
	output logic [router_link_pkg::DATA_W-1:0]   dat_o,
	// link pins
	output logic [router_link_pkg::NIB_W-1:0]    txd_o,
	input  logic                                cts_i,
	input  logic [router_link_pkg::NIB_W-1:0]    rxd_i
);
	import router_link_pkg::*;

	logic              tx_wr;
	logic              rx_rd;
	logic [DATA_W-1:0] rx_dat;
	link_status_t      status;

	// ====================
	// register decoder
	// ====================
	router_link_regs u_regs (
		.rst_i    (rst_i),
		.sclk     (sclk),
		.wb_req_i (wb_req_i),
		.cs_i     (cs_i),
		.ack_o    (ack_o),
		.dat_o    (dat_o),
		.tx_wr_o  (tx_wr),
		.rx_rd_o  (rx_rd),
		.status_i (status),
		.rx_dat_i (rx_dat)
	);

	// write data goes straight from the bus
	router_tx_bs u_tx (
		.rst_i   (rst_i),
		.sclk    (sclk),
		.wr_i    (tx_wr),
		.dat_i   (wb_req_i.dat),
		.cts_i   (cts_i),
		.txd_o   (txd_o),
		.empty_o (status.tx_empty),
		.busy_o  (status.tx_busy)
	);

	router_rx_bs u_rx (
		.rst_i       (rst_i),
		.sclk        (sclk),
		.rxd_i       (rxd_i),
		.rd_i        (rx_rd),
		.dat_o       (rx_dat),
		.ready_o     (status.rx_ready),
		.frame_err_o (status.rx_frame_err)
	);

endmodule

/* hw/router_link_regs.sv */
`timescale 1ns/100ps

module router_link_regs (
	input  logic                                rst_i,
	input  logic                                sclk,
	input  router_link_pkg::wb_req_t            wb_req_i,
	input  logic                                cs_i,
	output logic                                ack_o,
	output logic [router_link_pkg::DATA_W-1:0]   dat_o,
	output logic                                tx_wr_o,   // level while write acked
	output logic                                rx_rd_o,   // one clock per read cycle
	input  router_link_pkg::link_status_t       status_i,
	input  logic [router_link_pkg::DATA_W-1:0]   rx_dat_i
);
	import router_link_pkg::*;

	logic sel_tx;     // per register chip selects
	logic sel_rx;
	logic sel_st;
	logic rx_rd_lvl;  // acked RXDATA read, level
	logic rx_rd_q;

	// ====================
	// decode
	// ====================
	assign ack_o  = wb_req_i.cyc & wb_req_i.stb & cs_i;  // no wait states
	assign sel_tx = ack_o & (wb_req_i.adr == ADR_TXDATA);
	assign sel_rx = ack_o & (wb_req_i.adr == ADR_RXDATA);
	assign sel_st = ack_o & (wb_req_i.adr == ADR_STATUS);

	assign tx_wr_o   = sel_tx & wb_req_i.we;   // tx_bs finds the edge itself
	assign rx_rd_lvl = sel_rx & ~wb_req_i.we;
	assign rx_rd_o   = rx_rd_lvl & ~rx_rd_q;   // first acked cycle only

	always_ff @(posedge sclk) begin
		if (rst_i)
			rx_rd_q <= 1'b0;
		else
			rx_rd_q <= rx_rd_lvl;
	end

	// ====================
	// read mux
	// ====================
	always_comb begin
		dat_o = '0;
		if (sel_rx)
			dat_o = rx_dat_i;
		else if (sel_st)
			dat_o = DATA_W'(status_i);  // flags in the low 4 bits
	end

endmodule

/* hw/router_rx_bs.sv */
`timescale 1ns/100ps

module router_rx_bs (
	input  logic                              rst_i,
	input  logic                              sclk,
	input  logic [router_link_pkg::NIB_W-1:0]  rxd_i,
	input  logic                              rd_i,        // RXDATA read pulse
	output logic [router_link_pkg::DATA_W-1:0] dat_o,
	output logic                              ready_o,     // word waiting
	output logic                              frame_err_o  // last stop nibble bad
);
	import router_link_pkg::*;

	logic              active;     // inside a frame
	logic [CNT_W-1:0]  cnt;        // frame cycle, start nibble seen at 0
	logic              hunt_hit;   // start nibble while idle
	logic              mid_pt;     // middle of a nibble
	logic              data_pt;    // sample point of a data nibble
	logic              stop_pt;
	logic              end_pt;     // last cycle of the frame
	logic              stop_bad;   // stop nibble was not F
	logic [DATA_W-1:0] shreg;      // assembly register

	// ====================
	// sample strobes
	// ====================
	assign hunt_hit = ~active & (rxd_i == START_NIB);
	assign mid_pt   = (cnt[NIB_CNT_W-1:0] == RX_MID);
	assign data_pt  = active & mid_pt & (cnt >= RX_FIRST) & (cnt <= RX_LAST_DATA);
	assign stop_pt  = active & (cnt == RX_STOP);
	assign end_pt   = active & (cnt == FRAME_LAST);

	// frame counter and hunt state
	always_ff @(posedge sclk) begin
		if (rst_i) begin
			active <= 1'b0;
			cnt    <= '0;
		end else begin
			if (hunt_hit) begin
				active <= 1'b1;
				cnt    <= CNT_W'(1);  // next clock is cycle 1
			end else if (active) begin
				cnt <= cnt + CNT_W'(1);
				if (end_pt) begin
					active <= 1'b0;   // hunt again next cycle
					cnt    <= '0;
				end
			end
		end
	end

	// ====================
	// data path
	// ====================
	always_ff @(posedge sclk) begin
		if (data_pt)
			shreg <= {rxd_i, shreg[DATA_W-1:NIB_W]};  // lsn first, ends at bottom
		if (stop_pt)
			stop_bad <= (rxd_i != STOP_NIB);
		if (end_pt)
			dat_o <= shreg;  // overwrites an unread word
	end

	// ====================
	// status flags
	// ====================
	always_ff @(posedge sclk) begin
		if (rst_i) begin
			ready_o     <= 1'b0;
			frame_err_o <= 1'b0;
		end else begin
			if (rd_i) begin
				ready_o     <= 1'b0;
				frame_err_o <= 1'b0;
			end
			// a frame ending wins over a read in the same clock
			if (end_pt) begin
				ready_o     <= 1'b1;
				frame_err_o <= stop_bad;
			end
		end
	end

endmodule

/* hw/router_tx_bs.sv */
`timescale 1ns/100ps

module router_tx_bs (
	input  logic                              rst_i,
	input  logic                              sclk,
	input  logic                              wr_i,    // acked TXDATA write, level
	input  logic [router_link_pkg::DATA_W-1:0] dat_i,
	input  logic                              cts_i,   // peer clear to send
	output logic [router_link_pkg::NIB_W-1:0]  txd_o,
	output logic                              empty_o, // holding reg free
	output logic                              busy_o   // frame on the line
);
	import router_link_pkg::*;

	logic                wr_q;     // wr_i delayed for edge detect
	logic                wr_pe;    // first cycle of a write
	logic                txing;
	logic                sent_q;   // word moved to shifter last clock
	logic                frame_end;
	logic                can_load;
	logic [CNT_W-1:0]    cnt;      // clock count within the frame
	logic [DATA_W-1:0]   hold;     // holding register
	logic [FRAME_W-1:0]  shreg;    // stop, data, start

	assign wr_pe     = wr_i & ~wr_q;
	assign frame_end = (cnt == FRAME_LAST);
	assign can_load  = frame_end | ~txing;  // line free this cycle
	assign txd_o     = shreg[NIB_W-1:0];    // lowest nibble drives the pins
	assign busy_o    = txing;

	// ====================
	// holding register
	// ====================
	always_ff @(posedge sclk) begin
		if (wr_pe)
			hold <= dat_i;  // a write while full just overwrites
	end

	always_ff @(posedge sclk) begin
		if (rst_i) begin
			wr_q    <= 1'b0;
			empty_o <= 1'b1;
		end else begin
			wr_q <= wr_i;
			if (wr_pe)
				empty_o <= 1'b0;
			else if (sent_q)
				empty_o <= 1'b1;  // one clock after the start nibble shows
		end
	end

	// ====================
	// frame sequencer
	// ====================
	always_ff @(posedge sclk) begin
		if (rst_i) begin
			txing  <= 1'b0;
			sent_q <= 1'b0;
			cnt    <= '0;
			shreg  <= {FRAME_NIBS{IDLE_NIB}};  // line idles high
		end else begin
			sent_q <= 1'b0;
			cnt    <= cnt + CNT_W'(1);
			if (frame_end)
				txing <= 1'b0;
			if (can_load) begin
				cnt <= '0;
				// cts low keeps the word waiting in hold
				if (!empty_o && cts_i) begin
					txing  <= 1'b1;
					sent_q <= 1'b1;
					shreg  <= {STOP_NIB, hold, START_NIB};
				end
			end else if (cnt[NIB_CNT_W-1:0] == NIB_LAST) begin
				// next nibble, idle fill from the top
				shreg <= {IDLE_NIB, shreg[FRAME_W-1:NIB_W]};
			end
		end
	end

endmodule

/* hw/router_link_pkg.sv */
package router_link_pkg;

	// ====================
	// link geometry
	// ====================
	localparam int DATA_W     = 128;             // payload word
	localparam int NIB_W      = 4;               // link width
	localparam int NIB_CYC    = 4;               // clocks per nibble
	localparam int FRAME_NIBS = 34;              // start + 32 data + stop
	localparam int FRAME_CYC  = FRAME_NIBS * NIB_CYC;
	localparam int FRAME_W    = FRAME_NIBS * NIB_W;  // tx working register width
	localparam int CNT_W      = $clog2(FRAME_CYC);
	localparam int NIB_CNT_W  = $clog2(NIB_CYC);

	localparam logic [NIB_W-1:0] IDLE_NIB  = 4'hF;
	localparam logic [NIB_W-1:0] START_NIB = 4'h0;
	localparam logic [NIB_W-1:0] STOP_NIB  = 4'hF;

	// frame counter landmarks
	localparam logic [CNT_W-1:0]     FRAME_LAST   = CNT_W'(FRAME_CYC - 1);  // 135
	localparam logic [NIB_CNT_W-1:0] NIB_LAST     = NIB_CNT_W'(NIB_CYC - 1);
	localparam logic [NIB_CNT_W-1:0] RX_MID       = NIB_CNT_W'(NIB_CYC / 2);
	localparam logic [CNT_W-1:0]     RX_FIRST     = CNT_W'(NIB_CYC + NIB_CYC / 2);  // 6
	localparam logic [CNT_W-1:0]     RX_STOP      = CNT_W'(FRAME_CYC - NIB_CYC / 2); // 134
	localparam logic [CNT_W-1:0]     RX_LAST_DATA = CNT_W'(FRAME_CYC - NIB_CYC / 2 - NIB_CYC);

	// ====================
	// bus side types
	// ====================
	typedef enum logic [1:0] {
		ADR_TXDATA = 2'd0,   // write only
		ADR_RXDATA = 2'd1,   // read only
		ADR_STATUS = 2'd2    // read only
	} adr_e;

	typedef struct packed {
		logic              cyc;
		logic              stb;
		logic              we;
		adr_e              adr;
		logic [DATA_W-1:0] dat;
	} wb_req_t;

	// bit 3 down to bit 0 on the read bus
	typedef struct packed {
		logic tx_empty;
		logic tx_busy;
		logic rx_ready;
		logic rx_frame_err;
	} link_status_t;

endpackage
